// File: load_store_unit.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_access_check.sv
rtl/lsu_data_ram.sv
rtl/lsu_response.sv
rtl/load_store_unit.sv
tb/load_store_unit_sva.sv
tb/load_store_unit_tb.sv

// File: tb/load_store_unit_tb.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module load_store_unit_tb
	import lsu_pkg::*;
();

	// Request counts per test, upper bounds where random
	localparam int N_FILL    = 2 * `LSU_MEM_WORDS;
	localparam int N_SUB     = 8 * 12;
	localparam int N_EXT     = 16 * 13;
	localparam int N_FAULT   = 19;
	localparam int N_RAND    = 2 * 150;   // Store may be followed by a load
	localparam int N_TOTAL   = N_FILL + N_SUB + N_EXT + N_FAULT + N_RAND;
	localparam int MAX_CYCLES = 2 * N_TOTAL + 50;

	localparam logic [31:0] BASE = `LSU_BASE_ADDR;
	localparam logic [31:0] LAST = `LSU_BASE_ADDR + `LSU_MEM_BYTES; // First byte past memory

	logic                 clk;
	logic                 arst_n_i;
	logic                 req_i;
	lsu_op_e              op_i;
	logic [`LSU_XLEN-1:0] addr_i;
	logic [`LSU_XLEN-1:0] wdata_i;
	logic                 resp_valid_o;
	lsu_fault_e           resp_fault_o;
	logic [`LSU_XLEN-1:0] resp_rdata_o;

	logic [7:0]  ref_mem [0:`LSU_MEM_BYTES-1]; // Mirror of the data memory
	logic [31:0] lcg_state = 32'd21079;
	int          cycles  = 0;

	// Expected responses, oldest first
	lsu_fault_e  exp_fault_q [$];
	logic [31:0] exp_rdata_q [$];
	lsu_op_e     exp_op_q    [$];
	logic [31:0] exp_addr_q  [$];

	load_store_unit u_load_store_unit (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.req_i        (req_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.resp_valid_o (resp_valid_o),
		.resp_fault_o (resp_fault_o),
		.resp_rdata_o (resp_rdata_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int access_bytes(input lsu_op_e op);
		case (op)
			LSU_LB, LSU_LBU, LSU_SB: return 1;
			LSU_LH, LSU_LHU, LSU_SH: return 2;
			default:                 return 4;
		endcase
	endfunction

	// Expected fault and load data, stores update the mirror
	function automatic lsu_fault_e ref_access(input lsu_op_e op, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int              n;
		int              idx;
		int              i;
		longint unsigned a;
		logic [31:0]     raw;
		lsu_fault_e      f;
		n     = access_bytes(op);
		a     = addr;
		rdata = '0;
		raw   = '0;
		if ((n == 2 && addr[0]) || (n == 4 && addr[1:0] != 2'b00)) begin
			f = FAULT_ALIGN; // Checked before range
		end else if (a < BASE || a + n > longint'(BASE) + `LSU_MEM_BYTES) begin
			f = FAULT_RANGE;
		end else begin
			f = FAULT_NONE;
		end
		if (f == FAULT_NONE) begin
			idx = int'(a - BASE);
			if (op inside {LSU_SB, LSU_SH, LSU_SW}) begin
				for (i = 0; i < n; i++) ref_mem[idx + i] = wdata[8*i +: 8];
			end else begin
				for (i = 0; i < n; i++) raw[8*i +: 8] = ref_mem[idx + i]; // Little endian
				case (op)
					LSU_LB:  rdata = {{24{raw[7]}}, raw[7:0]};
					LSU_LH:  rdata = {{16{raw[15]}}, raw[15:0]};
					default: rdata = raw; // Upper bytes already zero
				endcase
			end
		end
		return f;
	endfunction

	task automatic stop_on_failure();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_fault(input lsu_fault_e got, input lsu_fault_e exp,
		input lsu_op_e op, input logic [31:0] addr);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s at %h gave fault %s, expected %s",
				$time, op.name(), addr, got.name(), exp.name());
			stop_on_failure();
		end
	endtask

	task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
		input lsu_op_e op, input logic [31:0] addr);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s at %h gave data %h, expected %h",
				$time, op.name(), addr, got, exp);
			stop_on_failure();
		end
	endtask

	// One request per call, back to back
	task automatic issue(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
		lsu_fault_e  f;
		logic [31:0] d;
		f = ref_access(op, addr, wdata, d);
		exp_fault_q.push_back(f);
		exp_rdata_q.push_back(d);
		exp_op_q.push_back(op);
		exp_addr_q.push_back(addr);
		@(posedge clk);
		req_i   <= 1'b1;
		op_i    <= op;
		addr_i  <= addr;
		wdata_i <= wdata;
	endtask

	function automatic lsu_op_e pick_op(input logic [2:0] sel);
		case (sel)
			3'd0:    return LSU_LB;
			3'd1:    return LSU_LH;
			3'd2:    return LSU_LW;
			3'd3:    return LSU_LBU;
			3'd4:    return LSU_LHU;
			3'd5:    return LSU_SB;
			3'd6:    return LSU_SH;
			default: return LSU_SW;
		endcase
	endfunction

	// Compare at mid cycle, outputs settled
	initial begin
		forever begin
			@(negedge clk);
			if (resp_valid_o) begin
				if (exp_fault_q.size() == 0) begin
					$display("Response seen at %0t ns with no request outstanding", $time);
					stop_on_failure();
				end
				check_fault(resp_fault_o, exp_fault_q[0], exp_op_q[0], exp_addr_q[0]);
				check_rdata(resp_rdata_o, exp_rdata_q[0], exp_op_q[0], exp_addr_q[0]);
				void'(exp_fault_q.pop_front());
				void'(exp_rdata_q.pop_front());
				void'(exp_op_q.pop_front());
				void'(exp_addr_q.pop_front());
			end
		end
	end

	// Watchdog
	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > MAX_CYCLES) begin
				$display("Timeout after %0d cycles, a response never arrived", cycles);
				stop_on_failure();
			end
		end
	end

	initial begin
		int          w;
		int          k;
		logic [31:0] r;
		logic [31:0] a;
		lsu_op_e     op;
		arst_n_i <= 1'b0;
		req_i    <= 1'b0;
		op_i     <= LSU_LW;
		addr_i   <= '0;
		wdata_i  <= '0;
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;

		// Word fill, then readback
		for (w = 0; w < `LSU_MEM_WORDS; w++) issue(LSU_SW, BASE + 4 * w, next_rand());
		for (w = 0; w < `LSU_MEM_WORDS; w++) issue(LSU_LW, BASE + 4 * w, '0);

		// Sub-word stores, each followed by a word readback
		repeat (8) begin
			w = int'(next_rand() % `LSU_MEM_WORDS);
			for (k = 0; k < 4; k++) begin
				issue(LSU_SB, BASE + 4 * w + k, next_rand());
				issue(LSU_LW, BASE + 4 * w, '0);
			end
			for (k = 0; k < 4; k += 2) begin
				issue(LSU_SH, BASE + 4 * w + k, next_rand());
				issue(LSU_LW, BASE + 4 * w, '0);
			end
		end

		// Load extension over random words
		repeat (16) begin
			w = int'(next_rand() % `LSU_MEM_WORDS);
			issue(LSU_SW, BASE + 4 * w, next_rand());
			for (k = 0; k < 4; k++) begin
				issue(LSU_LB, BASE + 4 * w + k, '0);
				issue(LSU_LBU, BASE + 4 * w + k, '0);
			end
			for (k = 0; k < 4; k += 2) begin
				issue(LSU_LH, BASE + 4 * w + k, '0);
				issue(LSU_LHU, BASE + 4 * w + k, '0);
			end
		end

		// Alignment faults
		issue(LSU_LH, BASE + 1, '0);
		issue(LSU_LHU, BASE + 3, '0);
		issue(LSU_SH, BASE + 5, next_rand());
		issue(LSU_LW, BASE + 2, '0);
		issue(LSU_LW, BASE + 7, '0);
		issue(LSU_SW, BASE + 9, next_rand());
		issue(LSU_LW, LAST + 2, '0);          // Both faults, alignment wins
		// Range faults below and past the window
		issue(LSU_LB, BASE - 1, '0);
		issue(LSU_LW, BASE - 4, '0);
		issue(LSU_LHU, BASE - 2, '0);
		issue(LSU_LW, LAST, '0);
		issue(LSU_LBU, LAST + 3, '0);
		issue(LSU_SW, LAST, next_rand());     // RAM index wraps to word 0
		issue(LSU_SW, BASE - 4, next_rand()); // Wraps to the last word
		issue(LSU_LW, 32'hFFFF_FFFC, '0);
		// Faulting stores left memory alone
		issue(LSU_LW, BASE, '0);
		issue(LSU_LW, LAST - 4, '0);
		issue(LSU_LW, BASE + 4, '0);
		issue(LSU_LW, BASE + 8, '0);

		// Random mix on consecutive cycles, few words for frequent hits
		repeat (150) begin
			r  = next_rand();
			op = pick_op(r[2:0]);
			if (r[7:4] == 4'hF) begin
				a = LAST + r[9:8];
			end else if (r[7:4] == 4'hE) begin
				a = BASE - 4 + r[9:8];
			end else begin
				a = BASE + {r[12:10], r[14:13]};
			end
			issue(op, a, next_rand());
			if (op inside {LSU_SB, LSU_SH, LSU_SW} && r[15]) begin
				issue(LSU_LW, {a[31:2], 2'b00}, '0); // Same word, through the bypass
			end
		end

		@(posedge clk);
		req_i <= 1'b0;
		while (exp_fault_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk); // Room for a stray response

		$display("Test OK");
		$finish;
	end

endmodule

// File: tb/load_store_unit_sva.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module load_store_unit_sva
	import lsu_pkg::*;
(
	input logic                 clk,
	input logic                 arst_n_i,
	input logic                 req_i,
	input logic                 resp_valid_i,
	input lsu_fault_e           resp_fault_i,
	input logic [`LSU_XLEN-1:0] resp_rdata_i,
	input logic                 commit_i      // Store commit from u_resp
);

	// One response per request, exactly one cycle later
	a_resp_after_req: assert property (@(posedge clk) disable iff (!arst_n_i)
		req_i |=> resp_valid_i)
		else $error("resp_valid_o missing one cycle after req_i");

	a_no_resp_without_req: assert property (@(posedge clk) disable iff (!arst_n_i)
		!req_i |=> !resp_valid_i)
		else $error("resp_valid_o high without a request one cycle before");

	// Stage valid is cleared by the asynchronous reset
	a_quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> !resp_valid_i)
		else $error("resp_valid_o high during reset");

	// Faulting stores never reach the RAM
	a_commit_clean: assert property (@(posedge clk) commit_i |-> resp_fault_i == FAULT_NONE)
		else $error("Store commit together with a fault code");

	a_rdata_idle_zero: assert property (@(posedge clk) !resp_valid_i |-> resp_rdata_i == '0)
		else $error("resp_rdata_o not zero outside a response");

endmodule

bind load_store_unit load_store_unit_sva u_sva (
	.clk          (clk),
	.arst_n_i     (arst_n_i),
	.req_i        (req_i),
	.resp_valid_i (resp_valid_o),
	.resp_fault_i (resp_fault_o),
	.resp_rdata_i (resp_rdata_o),
	.commit_i     (commit)      // Same net as u_resp.commit_o
);

// File: rtl/load_store_unit.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module load_store_unit
	import lsu_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 req_i,        // One request per strobe
	input  lsu_op_e              op_i,
	input  logic [`LSU_XLEN-1:0] addr_i,
	input  logic [`LSU_XLEN-1:0] wdata_i,
	output logic                 resp_valid_o, // One cycle after req_i
	output lsu_fault_e           resp_fault_o,
	output logic [`LSU_XLEN-1:0] resp_rdata_o
);

	// Stage one outputs of the checker
	logic                   chk_valid;
	lsu_op_e                chk_op;
	logic [1:0]             chk_off;
	lsu_fault_e             chk_fault;
	logic [`LSU_WIDX_W-1:0] chk_idx;
	logic [3:0]             chk_be;
	logic [`LSU_XLEN-1:0]   chk_data;

	logic [`LSU_XLEN-1:0]   ram_word; // Raw word read in parallel
	logic                   commit;   // Store commit back to the RAM

	lsu_access_check u_check (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.req_i      (req_i),
		.op_i       (op_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.valid_o    (chk_valid),
		.op_o       (chk_op),
		.byte_off_o (chk_off),
		.fault_o    (chk_fault),
		.word_idx_o (chk_idx),
		.wr_be_o    (chk_be),
		.wr_data_o  (chk_data)
	);

	lsu_data_ram u_ram (
		.clk       (clk),
		.req_i     (req_i),
		.addr_i    (addr_i),
		.commit_i  (commit),
		.wr_idx_i  (chk_idx),
		.wr_be_i   (chk_be),
		.wr_data_i (chk_data),
		.rd_word_o (ram_word)
	);

	lsu_response u_resp (
		.valid_i      (chk_valid),
		.op_i         (chk_op),
		.byte_off_i   (chk_off),
		.fault_i      (chk_fault),
		.rd_word_i    (ram_word),
		.resp_valid_o (resp_valid_o),
		.resp_fault_o (resp_fault_o),
		.resp_rdata_o (resp_rdata_o),
		.commit_o     (commit)
	);

endmodule

// File: rtl/lsu_response.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_response
	import lsu_pkg::*;
(
	input  logic                 valid_i,      // Stage one valid
	input  lsu_op_e              op_i,
	input  logic [1:0]           byte_off_i,
	input  lsu_fault_e           fault_i,
	input  logic [`LSU_XLEN-1:0] rd_word_i,    // Word from the RAM
	output logic                 resp_valid_o,
	output lsu_fault_e           resp_fault_o,
	output logic [`LSU_XLEN-1:0] resp_rdata_o,
	output logic                 commit_o      // Store write to the RAM
);

	logic [`LSU_XLEN-1:0] lane_word; // Addressed byte moved to bit 0
	logic [7:0]           ld_byte;
	logic [15:0]          ld_half;
	logic [`LSU_XLEN-1:0] ld_data;
	logic                 is_store;
	logic                 clean;     // Valid and without fault

	assign lane_word = rd_word_i >> {byte_off_i, 3'b000};
	assign ld_byte   = lane_word[7:0];
	assign ld_half   = lane_word[15:0];

	assign is_store = op_i inside {LSU_SB, LSU_SH, LSU_SW};
	assign clean    = valid_i && (fault_i == FAULT_NONE);

	// Extension per opcode
	always_comb begin
		case (op_i)
			LSU_LB: begin
				ld_data = {{(`LSU_XLEN-8){ld_byte[7]}}, ld_byte};
			end
			LSU_LH: begin
				ld_data = {{(`LSU_XLEN-16){ld_half[15]}}, ld_half};
			end
			LSU_LBU: begin
				ld_data = {{(`LSU_XLEN-8){1'b0}}, ld_byte};
			end
			LSU_LHU: begin
				ld_data = {{(`LSU_XLEN-16){1'b0}}, ld_half};
			end
			LSU_LW: begin
				ld_data = rd_word_i; // Word is aligned, no shift needed
			end
			default: begin
				ld_data = '0; // Stores return nothing
			end
		endcase
	end

	// Response for the request taken one edge back
	assign resp_valid_o = valid_i;
	assign resp_fault_o = valid_i ? fault_i : FAULT_NONE;
	assign resp_rdata_o = clean ? ld_data : '0; // Faulting loads give zero

	// Memory changes only for a clean store
	assign commit_o = clean && is_store;

endmodule

// File: rtl/lsu_data_ram.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_data_ram (
	input  logic                   clk,
	input  logic                   req_i,     // Read strobe
	input  logic [`LSU_XLEN-1:0]   addr_i,    // Byte address of the read
	input  logic                   commit_i,  // Store commit from the response stage
	input  logic [`LSU_WIDX_W-1:0] wr_idx_i,
	input  logic [3:0]             wr_be_i,
	input  logic [`LSU_XLEN-1:0]   wr_data_i, // Already in its byte lanes
	output logic [`LSU_XLEN-1:0]   rd_word_o  // Registered raw word
);

	// One bank per byte lane
	logic [7:0] bank [0:3][0:`LSU_MEM_WORDS-1];

	logic [`LSU_WIDX_W-1:0] rd_idx;
	logic                   same_word; // Read hits the committing word

	// Low address bits only, out of range reads just wrap
	assign rd_idx = addr_i[`LSU_WIDX_W+1:2];

	assign same_word = commit_i && (wr_idx_i == rd_idx);

	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			// Byte enabled commit
			if (commit_i && wr_be_i[b]) begin
				bank[b][wr_idx_i] <= wr_data_i[8*b +: 8];
			end

			// Registered read
			if (req_i) begin
				if (same_word && wr_be_i[b]) begin
					rd_word_o[8*b +: 8] <= wr_data_i[8*b +: 8]; // Bypass new byte
				end else begin
					rd_word_o[8*b +: 8] <= bank[b][rd_idx];
				end
			end
		end
	end

endmodule

// File: rtl/lsu_access_check.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_access_check
	import lsu_pkg::*;
(
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   req_i,      // Request strobe
	input  lsu_op_e                op_i,
	input  logic [`LSU_XLEN-1:0]   addr_i,     // Byte address
	input  logic [`LSU_XLEN-1:0]   wdata_i,    // Store data, right aligned
	output logic                   valid_o,    // Stage one holds a request
	output lsu_op_e                op_o,
	output logic [1:0]             byte_off_o,
	output lsu_fault_e             fault_o,
	output logic [`LSU_WIDX_W-1:0] word_idx_o,
	output logic [3:0]             wr_be_o,    // Store byte enables
	output logic [`LSU_XLEN-1:0]   wr_data_o   // Store data in its lanes
);

	logic [2:0]           acc_bytes;  // 1, 2 or 4
	logic [1:0]           off;
	logic                 mis_align;
	logic [`LSU_XLEN:0]   last_byte;  // One bit wider so the sum never wraps
	logic [`LSU_XLEN:0]   mem_end;    // First byte past the memory
	logic                 in_range;
	lsu_fault_e           fault_d;
	logic [3:0]           be_d;
	logic [`LSU_XLEN-1:0] data_d;

	assign off = addr_i[1:0];

	// Access width from the opcode
	always_comb begin
		case (op_i)
			LSU_LB, LSU_LBU, LSU_SB: acc_bytes = 3'd1;
			LSU_LH, LSU_LHU, LSU_SH: acc_bytes = 3'd2;
			default:                 acc_bytes = 3'd4;
		endcase
	end

	// Halfwords need an even address, words a multiple of four
	assign mis_align = ((acc_bytes == 3'd2) && off[0]) ||
		((acc_bytes == 3'd4) && (off != 2'b00));

	// First and last byte must both fall inside the window
	assign last_byte = {1'b0, addr_i} + {{(`LSU_XLEN-2){1'b0}}, acc_bytes} - 1'b1;
	assign mem_end   = {1'b0, `LSU_BASE_ADDR} + `LSU_MEM_BYTES;
	assign in_range  = (addr_i >= `LSU_BASE_ADDR) && (last_byte < mem_end);

	// Alignment wins over range
	always_comb begin
		if (mis_align) begin
			fault_d = FAULT_ALIGN;
		end else if (!in_range) begin
			fault_d = FAULT_RANGE;
		end else begin
			fault_d = FAULT_NONE;
		end
	end

	// Store lanes, little endian
	assign data_d = wdata_i << {off, 3'b000};

	always_comb begin
		case (op_i)
			LSU_SB:  be_d = 4'b0001 << off;
			LSU_SH:  be_d = 4'b0011 << off;
			LSU_SW:  be_d = 4'b1111;
			default: be_d = 4'b0000; // Loads write nothing
		endcase
	end

	// Stage valid
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= req_i;
		end
	end

	// Stage payload, held between requests
	always_ff @(posedge clk) begin
		if (req_i) begin
			op_o       <= op_i;
			byte_off_o <= off;
			fault_o    <= fault_d;
			word_idx_o <= addr_i[`LSU_WIDX_W+1:2]; // Wraps like the RAM read
			wr_be_o    <= be_d;
			wr_data_o  <= data_d;
		end
	end

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

	// Load/store opcodes
	// Bit 3 marks a store, low bits follow the RV32 funct3 layout
	typedef enum logic [3:0] {
		LSU_LB  = 4'b0000, // Byte, sign extended
		LSU_LH  = 4'b0001, // Halfword, sign extended
		LSU_LW  = 4'b0010, // Full word
		LSU_LBU = 4'b0100, // Byte, zero extended
		LSU_LHU = 4'b0101, // Halfword, zero extended
		LSU_SB  = 4'b1000,
		LSU_SH  = 4'b1001,
		LSU_SW  = 4'b1010
	} lsu_op_e;

	// Fault code returned with each response
	typedef enum logic [1:0] {
		FAULT_NONE  = 2'd0,
		FAULT_RANGE = 2'd1, // Some byte of the access outside the memory
		FAULT_ALIGN = 2'd2  // Odd halfword or word off a 4-byte boundary
	} lsu_fault_e;

endpackage

// File: rtl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data memory size in bytes, power of two
`define LSU_MEM_BYTES 1024

// First byte address of the data memory
`define LSU_BASE_ADDR 32'h0100_0000 // Aligned to the memory size

// Address and data width of the core
`define LSU_XLEN 32

// Word index width into the memory, derived from the size above
`define LSU_WIDX_W ($clog2(`LSU_MEM_BYTES / 4))

// Number of 32-bit words in the memory
`define LSU_MEM_WORDS (`LSU_MEM_BYTES / 4)

`endif
